// File: Bender.yml
package:
  name: ext_harness

sources:
  # Shared package first
  - harness_pkg.sv

  # Design
  - power_switch_emu.sv
  - slow_memory.sv
  - ext_mem_router.sv
  - gpio_cnt.sv
  - ext_harness_top.sv

  # Testbench
  - target: test
    files:
      - tb_ext_harness.sv

// File: build.f
harness_pkg.sv
power_switch_emu.sv
slow_memory.sv
ext_mem_router.sv
gpio_cnt.sv
ext_harness_top.sv
tb_ext_harness.sv

// File: ext_harness_top.sv
/*
  External-side glue around the core: bus to two slow memories,
  power switch acks, JTAG source select and a GPIO event counter.
*/

`timescale 1ns/10ps

module ext_harness_top
  import harness_pkg::*;
#(
  parameter int unsigned GNT_LATENCY = 3,
  parameter int unsigned ACK_LATENCY = 15,
  parameter int unsigned EXT_DOMAINS = 1,
  parameter int unsigned CNT_MAX     = 2048,
  parameter bit          JTAG_SIM    = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Core bus
  input  logic                   bus_req_i,
  input  logic                   bus_we_i,
  input  logic [BE_W-1:0]        bus_be_i,
  input  logic [ADDR_W-1:0]      bus_addr_i,
  input  logic [DATA_W-1:0]      bus_wdata_i,
  output logic                   bus_gnt_o,
  output logic                   bus_rvalid_o,
  output logic [DATA_W-1:0]      bus_rdata_o,

  // Power switches
  input  logic                   cpu_switch_n_i,
  input  logic                   periph_switch_n_i,
  input  logic [EXT_DOMAINS-1:0] ext_switch_n_i,
  output logic                   cpu_ack_n_o,
  output logic                   periph_ack_n_o,
  output logic [EXT_DOMAINS-1:0] ext_ack_n_o,

  // JTAG pins, simulation source and core side
  input  logic                   jtag_tck_i,
  input  logic                   jtag_tms_i,
  input  logic                   jtag_tdi_i,
  input  logic                   jtag_trst_n_i,
  output logic                   jtag_tdo_o,
  input  logic                   sim_tck_i,
  input  logic                   sim_tms_i,
  input  logic                   sim_tdi_i,
  input  logic                   sim_trst_n_i,
  output logic                   sim_tdo_o,
  output logic                   core_tck_o,
  output logic                   core_tms_o,
  output logic                   core_tdi_o,
  output logic                   core_trst_n_o,
  input  logic                   core_tdo_i,

  // GPIO
  input  logic                   gpio_i,
  output logic                   gpio_event_o
);

  localparam int unsigned MEM_WORDS = 8192;

  logic              mem0_req, mem1_req;
  logic              mem0_we, mem1_we;
  logic [BE_W-1:0]   mem0_be, mem1_be;
  logic [MEM_AW-1:0] mem0_waddr, mem1_waddr;
  logic [DATA_W-1:0] mem0_wdata, mem1_wdata;
  logic              mem0_gnt, mem1_gnt;
  logic              mem0_rvalid, mem1_rvalid;
  logic [DATA_W-1:0] mem0_rdata, mem1_rdata;

  // --------------------------------------------------------------------------
  // Power switch emulation
  // --------------------------------------------------------------------------

  power_switch_emu #(
    .NUM_DOMAINS (1),
    .ACK_LATENCY (ACK_LATENCY)
  ) u_cpu_switch (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (cpu_switch_n_i),
    .ack_n_o    (cpu_ack_n_o)
  );

  power_switch_emu #(
    .NUM_DOMAINS (1),
    .ACK_LATENCY (ACK_LATENCY)
  ) u_periph_switch (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (periph_switch_n_i),
    .ack_n_o    (periph_ack_n_o)
  );

  power_switch_emu #(
    .NUM_DOMAINS (EXT_DOMAINS),
    .ACK_LATENCY (ACK_LATENCY)
  ) u_ext_switch (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (ext_switch_n_i),
    .ack_n_o    (ext_ack_n_o)
  );

  // --------------------------------------------------------------------------
  // External bus and slow memories
  // --------------------------------------------------------------------------

  ext_mem_router u_ext_mem_router (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bus_req_i     (bus_req_i),
    .bus_we_i      (bus_we_i),
    .bus_be_i      (bus_be_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_gnt_o     (bus_gnt_o),
    .bus_rvalid_o  (bus_rvalid_o),
    .bus_rdata_o   (bus_rdata_o),
    .mem0_req_o    (mem0_req),
    .mem0_we_o     (mem0_we),
    .mem0_be_o     (mem0_be),
    .mem0_waddr_o  (mem0_waddr),
    .mem0_wdata_o  (mem0_wdata),
    .mem0_gnt_i    (mem0_gnt),
    .mem0_rvalid_i (mem0_rvalid),
    .mem0_rdata_i  (mem0_rdata),
    .mem1_req_o    (mem1_req),
    .mem1_we_o     (mem1_we),
    .mem1_be_o     (mem1_be),
    .mem1_waddr_o  (mem1_waddr),
    .mem1_wdata_o  (mem1_wdata),
    .mem1_gnt_i    (mem1_gnt),
    .mem1_rvalid_i (mem1_rvalid),
    .mem1_rdata_i  (mem1_rdata)
  );

  slow_memory #(
    .NUM_WORDS   (MEM_WORDS),
    .GNT_LATENCY (GNT_LATENCY)
  ) u_slow_mem0 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (mem0_req),
    .we_i     (mem0_we),
    .be_i     (mem0_be),
    .waddr_i  (mem0_waddr),
    .wdata_i  (mem0_wdata),
    .gnt_o    (mem0_gnt),
    .rvalid_o (mem0_rvalid),
    .rdata_o  (mem0_rdata)
  );

  slow_memory #(
    .NUM_WORDS   (MEM_WORDS),
    .GNT_LATENCY (GNT_LATENCY)
  ) u_slow_mem1 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (mem1_req),
    .we_i     (mem1_we),
    .be_i     (mem1_be),
    .waddr_i  (mem1_waddr),
    .wdata_i  (mem1_wdata),
    .gnt_o    (mem1_gnt),
    .rvalid_o (mem1_rvalid),
    .rdata_o  (mem1_rdata)
  );

  // --------------------------------------------------------------------------
  // JTAG source select and GPIO counter
  // --------------------------------------------------------------------------

  assign core_tck_o    = JTAG_SIM ? sim_tck_i    : jtag_tck_i;
  assign core_tms_o    = JTAG_SIM ? sim_tms_i    : jtag_tms_i;
  assign core_tdi_o    = JTAG_SIM ? sim_tdi_i    : jtag_tdi_i;
  assign core_trst_n_o = JTAG_SIM ? sim_trst_n_i : jtag_trst_n_i;

  // Unused source sees a quiet tdo
  assign sim_tdo_o  = JTAG_SIM ? core_tdo_i : 1'b0;
  assign jtag_tdo_o = JTAG_SIM ? 1'b0 : core_tdo_i;

  gpio_cnt #(
    .CNT_MAX (CNT_MAX)
  ) u_gpio_cnt (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_event_o)
  );

endmodule

// File: ext_mem_router.sv
/*
  Routes the core bus to one of two slow memories by address.
  Unmapped addresses fall through to memory 0.
*/

`timescale 1ns/10ps

module ext_mem_router
  import harness_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Core side
  input  logic              bus_req_i,
  input  logic              bus_we_i,
  input  logic [BE_W-1:0]   bus_be_i,
  input  logic [ADDR_W-1:0] bus_addr_i,
  input  logic [DATA_W-1:0] bus_wdata_i,
  output logic              bus_gnt_o,
  output logic              bus_rvalid_o,
  output logic [DATA_W-1:0] bus_rdata_o,

  // Memory 0
  output logic              mem0_req_o,
  output logic              mem0_we_o,
  output logic [BE_W-1:0]   mem0_be_o,
  output logic [MEM_AW-1:0] mem0_waddr_o,
  output logic [DATA_W-1:0] mem0_wdata_o,
  input  logic              mem0_gnt_i,
  input  logic              mem0_rvalid_i,
  input  logic [DATA_W-1:0] mem0_rdata_i,

  // Memory 1
  output logic              mem1_req_o,
  output logic              mem1_we_o,
  output logic [BE_W-1:0]   mem1_be_o,
  output logic [MEM_AW-1:0] mem1_waddr_o,
  output logic [DATA_W-1:0] mem1_wdata_o,
  input  logic              mem1_gnt_i,
  input  logic              mem1_rvalid_i,
  input  logic [DATA_W-1:0] mem1_rdata_i
);

  logic              sel_mem1;
  logic [ADDR_W-1:0] mem1_offset;
  logic [MEM_AW-1:0] waddr;
  logic              tgt_q;

  // --------------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------------

  // Unsigned wrap makes addresses below the base land far outside the span
  assign mem1_offset = bus_addr_i - MEM1_BASE;
  assign sel_mem1    = (mem1_offset < MEM_SPAN);
  assign waddr       = bus_addr_i[MEM_AW+1:2];

  assign mem0_req_o   = bus_req_i && !sel_mem1;
  assign mem0_we_o    = bus_we_i;
  assign mem0_be_o    = bus_be_i;
  assign mem0_waddr_o = waddr;
  assign mem0_wdata_o = bus_wdata_i;

  assign mem1_req_o   = bus_req_i && sel_mem1;
  assign mem1_we_o    = bus_we_i;
  assign mem1_be_o    = bus_be_i;
  assign mem1_waddr_o = waddr;
  assign mem1_wdata_o = bus_wdata_i;

  assign bus_gnt_o = sel_mem1 ? mem1_gnt_i : mem0_gnt_i;

  // --------------------------------------------------------------------------
  // Response path
  // --------------------------------------------------------------------------

  // Target of the last granted access, the response follows one cycle later
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tgt_q <= 1'b0;
    end else if (bus_req_i && bus_gnt_o) begin
      tgt_q <= sel_mem1;
    end
  end

  assign bus_rvalid_o = tgt_q ? mem1_rvalid_i : mem0_rvalid_i;
  assign bus_rdata_o  = tgt_q ? mem1_rdata_i : mem0_rdata_i;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  property p_single_rvalid;
    @(posedge clk_i) disable iff (!rst_n_i)
      !(mem0_rvalid_i && mem1_rvalid_i);
  endproperty

  a_single_rvalid : assert property (p_single_rvalid)
    else $error("both memories answered in the same cycle");

endmodule

// File: gpio_cnt.sv
/*
  Counts rising edges on an asynchronous GPIO line.
  Gives a one-cycle pulse every CNT_MAX edges.
*/

`timescale 1ns/10ps

module gpio_cnt
  import harness_pkg::*;
#(
  parameter int unsigned CNT_MAX = 2048
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic gpio_i,
  output logic gpio_o
);

  localparam int unsigned CNT_W = (CNT_MAX > 1) ? $clog2(CNT_MAX) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CNT_MAX - 1);

  logic [1:0]       sync_q;
  logic             prev_q;
  logic             rise;
  logic [CNT_W-1:0] cnt_q;
  logic             pulse_q;

  // Two-flop synchronizer, then edge detect on the synced level
  assign rise = sync_q[1] && !prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q  <= 2'b00;
      prev_q  <= 1'b0;
      cnt_q   <= '0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], gpio_i};
      prev_q  <= sync_q[1];
      pulse_q <= 1'b0;
      if (rise) begin
        if (cnt_q == CNT_LAST) begin
          cnt_q   <= '0;
          pulse_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign gpio_o = pulse_q;

endmodule

// File: harness_pkg.sv
/*
  Shared bus widths and memory map of the external harness.
  Imported by every harness module.
*/

package harness_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------

  // Byte address and data word of the core bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // One enable per data byte
  localparam int unsigned BE_W = DATA_W / 8;

  // Word address inside one slow memory, taken from byte address bits 15:2
  localparam int unsigned MEM_AW = 14;

  // --------------------------------------------------------------------------
  // Memory map
  // --------------------------------------------------------------------------

  // Memory 0 is also the default target for any unmapped address
  localparam logic [ADDR_W-1:0] MEM0_BASE = 32'hF000_0000;

  // Memory 1 sits right above memory 0
  localparam logic [ADDR_W-1:0] MEM1_BASE = 32'hF000_8000;

  // 32 KiB per window
  localparam logic [ADDR_W-1:0] MEM_SPAN = 32'h0000_8000;

endpackage

// File: power_switch_emu.sv
/*
  Emulates power switches that acknowledge a request after a fixed delay.
  One active-low switch and ack bit per power domain.
*/

`timescale 1ns/10ps

module power_switch_emu
  import harness_pkg::*;
#(
  parameter int unsigned NUM_DOMAINS = 1,
  parameter int unsigned ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [NUM_DOMAINS-1:0] switch_n_i,
  output logic [NUM_DOMAINS-1:0] ack_n_o
);

  // Settling time of the switch, one stage per cycle
  logic [NUM_DOMAINS-1:0] stage_q [ACK_LATENCY];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ACK_LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign ack_n_o = stage_q[ACK_LATENCY-1];

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Any switch change shows up on the ack exactly ACK_LATENCY cycles later
  property p_ack_follows_switch;
    @(posedge clk_i) disable iff (!rst_n_i)
      $changed(switch_n_i) |->
        ##ACK_LATENCY (ack_n_o == $past(switch_n_i, ACK_LATENCY));
  endproperty

  a_ack_follows_switch : assert property (p_ack_follows_switch)
    else $error("power switch ack does not follow its switch");

endmodule

// File: slow_memory.sv
/*
  Word-addressed slow memory on a req/gnt/rvalid port.
  Grants after a fixed wait, answers every granted access one cycle later.
*/

`timescale 1ns/10ps

module slow_memory
  import harness_pkg::*;
#(
  parameter int unsigned NUM_WORDS   = 8192,
  parameter int unsigned GNT_LATENCY = 3
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [MEM_AW-1:0] waddr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int unsigned IDX_W = $clog2(NUM_WORDS);
  localparam int unsigned CNT_W = (GNT_LATENCY > 1) ? $clog2(GNT_LATENCY) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(GNT_LATENCY - 1);

  logic [DATA_W-1:0] mem_q [NUM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]  idx;

  logic              pend_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              rvalid_q;
  logic              access;

  assign idx    = waddr_i[IDX_W-1:0];
  assign gnt_o  = pend_q && (cnt_q == CNT_LAST);
  assign access = req_i && gnt_o;

  // --------------------------------------------------------------------------
  // Grant wait
  // --------------------------------------------------------------------------

  // A new wait starts only when no grant is pending
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q   <= 1'b0;
      cnt_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access;
      if (!pend_q) begin
        if (req_i) begin
          pend_q <= 1'b1;
          cnt_q  <= '0;
        end
      end else if (gnt_o) begin
        pend_q <= 1'b0;
        cnt_q  <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Master keeps the request and its fields until the grant
  property p_req_held;
    @(posedge clk_i) disable iff (!rst_n_i)
      (req_i && !gnt_o) |=>
        (req_i && $stable({we_i, be_i, waddr_i, wdata_i}));
  endproperty

  a_req_held : assert property (p_req_held)
    else $error("request dropped or changed before grant");

endmodule

// File: tb_ext_harness.sv
/*
  Self-checking testbench for the external harness top level.
  Runs a table of bus accesses, then the power switches, GPIO counter and JTAG select.
*/

`timescale 1ns/10ps

module tb_ext_harness
  import harness_pkg::*;
();

  localparam int unsigned GNT_LAT   = 3;
  localparam int unsigned ACK_LAT   = 15;
  localparam int unsigned EXT_DOM   = 2;
  localparam int unsigned CNT_LIMIT = 4;
  localparam int unsigned TIMEOUT   = 100;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
  } bus_row_t;

  logic               clk_i;
  logic               rst_n_i;
  logic               bus_req_i;
  logic               bus_we_i;
  logic [BE_W-1:0]    bus_be_i;
  logic [ADDR_W-1:0]  bus_addr_i;
  logic [DATA_W-1:0]  bus_wdata_i;
  logic               bus_gnt_o;
  logic               bus_rvalid_o;
  logic [DATA_W-1:0]  bus_rdata_o;
  logic               cpu_switch_n_i;
  logic               periph_switch_n_i;
  logic [EXT_DOM-1:0] ext_switch_n_i;
  logic               cpu_ack_n_o;
  logic               periph_ack_n_o;
  logic [EXT_DOM-1:0] ext_ack_n_o;
  logic               jtag_tck_i;
  logic               jtag_tms_i;
  logic               jtag_tdi_i;
  logic               jtag_trst_n_i;
  logic               jtag_tdo_o;
  logic               sim_tck_i;
  logic               sim_tms_i;
  logic               sim_tdi_i;
  logic               sim_trst_n_i;
  logic               sim_tdo_o;
  logic               core_tck_o;
  logic               core_tms_o;
  logic               core_tdi_o;
  logic               core_trst_n_o;
  logic               core_tdo_i;
  logic               gpio_i;
  logic               gpio_event_o;

  bus_row_t    bus_table[$];
  int unsigned event_cnt = 0;

  ext_harness_top #(
    .GNT_LATENCY (GNT_LAT),
    .ACK_LATENCY (ACK_LAT),
    .EXT_DOMAINS (EXT_DOM),
    .CNT_MAX     (CNT_LIMIT),
    .JTAG_SIM    (1'b0)
  ) u_ext_harness_top (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .bus_req_i         (bus_req_i),
    .bus_we_i          (bus_we_i),
    .bus_be_i          (bus_be_i),
    .bus_addr_i        (bus_addr_i),
    .bus_wdata_i       (bus_wdata_i),
    .bus_gnt_o         (bus_gnt_o),
    .bus_rvalid_o      (bus_rvalid_o),
    .bus_rdata_o       (bus_rdata_o),
    .cpu_switch_n_i    (cpu_switch_n_i),
    .periph_switch_n_i (periph_switch_n_i),
    .ext_switch_n_i    (ext_switch_n_i),
    .cpu_ack_n_o       (cpu_ack_n_o),
    .periph_ack_n_o    (periph_ack_n_o),
    .ext_ack_n_o       (ext_ack_n_o),
    .jtag_tck_i        (jtag_tck_i),
    .jtag_tms_i        (jtag_tms_i),
    .jtag_tdi_i        (jtag_tdi_i),
    .jtag_trst_n_i     (jtag_trst_n_i),
    .jtag_tdo_o        (jtag_tdo_o),
    .sim_tck_i         (sim_tck_i),
    .sim_tms_i         (sim_tms_i),
    .sim_tdi_i         (sim_tdi_i),
    .sim_trst_n_i      (sim_trst_n_i),
    .sim_tdo_o         (sim_tdo_o),
    .core_tck_o        (core_tck_o),
    .core_tms_o        (core_tms_o),
    .core_tdi_o        (core_tdi_o),
    .core_trst_n_o     (core_trst_n_o),
    .core_tdo_i        (core_tdo_i),
    .gpio_i            (gpio_i),
    .gpio_event_o      (gpio_event_o)
  );

  always #4 clk_i = ~clk_i;

  // Event pulses seen on the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i && gpio_event_o) begin
      event_cnt <= event_cnt + 1;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                         $time, name, got, exp));
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge clk_i);
  endtask

  // Unmapped addresses fold into memory 0 at byte address bits 15:2
  function automatic logic [ADDR_W-1:0] mem0_alias(input logic [ADDR_W-1:0] addr);
    return MEM0_BASE | {16'h0000, addr[15:2], 2'b00};
  endfunction

  task automatic add_row(input logic we, input logic [ADDR_W-1:0] addr,
                         input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata,
                         input logic [DATA_W-1:0] rdata);
    bus_row_t row;
    row.we    = we;
    row.addr  = addr;
    row.be    = be;
    row.wdata = wdata;
    row.rdata = rdata;
    bus_table.push_back(row);
  endtask

  task automatic bus_access(input bus_row_t row);
    int unsigned cyc;
    bit          seen;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= row.we;
    bus_be_i    <= row.be;
    bus_addr_i  <= row.addr;
    bus_wdata_i <= row.wdata;
    cyc  = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      if (bus_gnt_o) begin
        seen = 1'b1;
      end else begin
        cyc++;
        if (cyc > TIMEOUT) fail_run("Bus grant never came for a pending request");
      end
    end
    check_value("bus_gnt_o latency", cyc, GNT_LAT);
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    cyc  = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      cyc++;
      if (bus_rvalid_o) begin
        seen = 1'b1;
      end else if (cyc > TIMEOUT) begin
        fail_run("Bus response never came after a grant");
      end
    end
    check_value("bus_rvalid_o latency", cyc, 1);
    if (!row.we) begin
      check_value("bus_rdata_o", bus_rdata_o, row.rdata);
    end
  endtask

  // Bit 0 cpu, bit 1 periph, upper bits external domains
  task automatic switch_step(input logic [EXT_DOM+1:0] sw);
    logic [EXT_DOM+1:0] ack;
    int unsigned        cyc;
    bit                 seen;
    @(posedge clk_i);
    cpu_switch_n_i    <= sw[0];
    periph_switch_n_i <= sw[1];
    ext_switch_n_i    <= sw[EXT_DOM+1:2];
    cyc  = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      ack = {ext_ack_n_o, periph_ack_n_o, cpu_ack_n_o};
      if (ack == sw) begin
        seen = 1'b1;
      end else begin
        cyc++;
        if (cyc > TIMEOUT) fail_run("Power switch acknowledge never followed its switch");
      end
    end
    check_value("ack_n latency", cyc, ACK_LAT);
  endtask

  task automatic gpio_edge();
    @(posedge clk_i);
    gpio_i <= 1'b1;
    idle_cycles(3);
    gpio_i <= 1'b0;
    idle_cycles(3);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    logic [EXT_DOM+1:0] sw;
    logic [3:0]         pat;
    int unsigned        cyc;

    clk_i             = 1'b0;
    rst_n_i           = 1'b0;
    bus_req_i         = 1'b0;
    bus_we_i          = 1'b0;
    bus_be_i          = '0;
    bus_addr_i        = '0;
    bus_wdata_i       = '0;
    cpu_switch_n_i    = 1'b1;
    periph_switch_n_i = 1'b1;
    ext_switch_n_i    = '1;
    jtag_tck_i        = 1'b0;
    jtag_tms_i        = 1'b0;
    jtag_tdi_i        = 1'b0;
    jtag_trst_n_i     = 1'b0;
    sim_tck_i         = 1'b0;
    sim_tms_i         = 1'b0;
    sim_tdi_i         = 1'b0;
    sim_trst_n_i      = 1'b0;
    core_tdo_i        = 1'b0;
    gpio_i            = 1'b0;

    idle_cycles(8);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("bus_gnt_o", bus_gnt_o, 0);
    check_value("bus_rvalid_o", bus_rvalid_o, 0);
    check_value("gpio_event_o", gpio_event_o, 0);
    check_value("ack_n after reset", {ext_ack_n_o, periph_ack_n_o, cpu_ack_n_o}, 4'hF);

    // Same offset in both windows, partial write merge, unmapped fold-back
    add_row(1'b1, MEM0_BASE + 32'h10, 4'hF, 32'h1111_AAAA, 32'h0);
    add_row(1'b1, MEM1_BASE + 32'h10, 4'hF, 32'h2222_BBBB, 32'h0);
    add_row(1'b0, MEM0_BASE + 32'h10, 4'hF, 32'h0, 32'h1111_AAAA);
    add_row(1'b0, MEM1_BASE + 32'h10, 4'hF, 32'h0, 32'h2222_BBBB);
    add_row(1'b1, MEM0_BASE + 32'h20, 4'hF, 32'hDEAD_BEEF, 32'h0);
    add_row(1'b1, MEM0_BASE + 32'h20, 4'b0101, 32'h1234_5678, 32'h0);
    add_row(1'b0, MEM0_BASE + 32'h20, 4'hF, 32'h0, 32'hDE34_BE78);
    add_row(1'b1, 32'h0000_1040, 4'hF, 32'h5A5A_0001, 32'h0);
    add_row(1'b0, mem0_alias(32'h0000_1040), 4'hF, 32'h0, 32'h5A5A_0001);
    add_row(1'b1, 32'h8000_7FFC, 4'hF, 32'h0BAD_F00D, 32'h0);
    add_row(1'b0, mem0_alias(32'h8000_7FFC), 4'hF, 32'h0, 32'h0BAD_F00D);
    add_row(1'b0, MEM1_BASE + 32'h10, 4'hF, 32'h0, 32'h2222_BBBB);

    foreach (bus_table[i]) begin
      bus_access(bus_table[i]);
    end

    // Each switch on, then off again
    for (int d = 0; d < EXT_DOM + 2; d++) begin
      sw    = '1;
      sw[d] = 1'b0;
      switch_step(sw);
      switch_step('1);
    end

    // Three edges stay below the limit
    repeat (3) gpio_edge();
    idle_cycles(10);
    check_value("gpio_event_o count", event_cnt, 0);
    gpio_edge();
    cyc = 0;
    while (event_cnt == 0) begin
      @(negedge clk_i);
      cyc++;
      if (cyc > TIMEOUT) fail_run("GPIO event pulse never came after the fourth edge");
    end
    idle_cycles(10);
    check_value("gpio_event_o count", event_cnt, 1);

    // Pin source selected, sim inputs driven opposite
    for (int i = 0; i < 16; i++) begin
      pat = i[3:0];
      @(posedge clk_i);
      jtag_tck_i    <= pat[0];
      jtag_tms_i    <= pat[1];
      jtag_tdi_i    <= pat[2];
      jtag_trst_n_i <= pat[3];
      sim_tck_i     <= ~pat[0];
      sim_tms_i     <= ~pat[1];
      sim_tdi_i     <= ~pat[2];
      sim_trst_n_i  <= ~pat[3];
      core_tdo_i    <= pat[1] ^ pat[2];
      @(negedge clk_i);
      check_value("core_tck_o", core_tck_o, pat[0]);
      check_value("core_tms_o", core_tms_o, pat[1]);
      check_value("core_tdi_o", core_tdi_o, pat[2]);
      check_value("core_trst_n_o", core_trst_n_o, pat[3]);
      check_value("jtag_tdo_o", jtag_tdo_o, pat[1] ^ pat[2]);
      check_value("sim_tdo_o", sim_tdo_o, 0);
    end

    idle_cycles(2);
    $display("STATUS: PASS");
    $finish;
  end

endmodule
